// ==== design/bpu_macros.svh ====
/* Table sizing and host register map of the branch predictor.
   Included by the package and by any RTL that needs one of these constants. */
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// Pattern history table
`define BPU_TABLE_DEPTH_EXP2 10
`define BPU_CTR_WIDTH 2
`define BPU_CTR_INIT 1

// Index is taken from PC bits 11:2
`define BPU_PC_WIDTH 32
`define BPU_PC_IDX_LSB 2

// Host port map with the table below the stats block
`define BPU_AXIL_ADDR_WIDTH 13
`define BPU_AXIL_DATA_WIDTH 32
`define BPU_STAT_BASE 13'h1000
`define BPU_STAT_UPDATES (`BPU_STAT_BASE)
`define BPU_STAT_MISPREDICTS (`BPU_STAT_BASE + 13'h4)

`endif

// ==== design/bpu_pkg.sv ====
/* Types shared by the predictor RTL and its testbench */
`include "bpu_macros.svh"

package bpu_pkg;

    typedef logic [`BPU_CTR_WIDTH-1:0] ctr_t;
    typedef logic [`BPU_TABLE_DEPTH_EXP2-1:0] pht_idx_t;
    typedef logic [`BPU_PC_WIDTH-1:0] pc_t;

    typedef struct packed {
        logic valid;
        pc_t  pc;
    } fetch_query_t;

    typedef struct packed {
        logic valid;
        logic taken;
    } pred_t;

    // ctr_bits is the counter seen when the branch was predicted
    typedef struct packed {
        logic valid;
        logic taken;
        pc_t  pc;
        ctr_t ctr_bits;
    } commit_update_t;

    typedef struct packed {
        logic     valid;
        logic     write;
        pht_idx_t idx;
        ctr_t     wdata;
    } pht_req_t;

    typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} axil_resp_e;

    typedef enum logic [1:0] {IDLE, TABLE_WAIT, RESP} host_state_e;

    typedef enum logic [`BPU_CTR_WIDTH-1:0] {STRONG_NT, WEAK_NT, WEAK_T, STRONG_T} ctr_dir_e;

endpackage

// ==== design/bpu_pht_ram.sv ====
/* Dual-port block RAM holding the PHT counters.
   Both ports read through a register and port B also writes and returns the old word. */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bpu_pht_ram #(
    parameter int DATA_WIDTH = 2,
    parameter int DEPTH_EXP2 = 10
) (
    input  logic                  clk,
    input  logic [DEPTH_EXP2-1:0] addra,
    output logic [DATA_WIDTH-1:0] douta,
    input  logic                  web,
    input  logic [DEPTH_EXP2-1:0] addrb,
    input  logic [DATA_WIDTH-1:0] dinb,
    output logic [DATA_WIDTH-1:0] doutb
);

    logic [DATA_WIDTH-1:0] mem [0:(1<<DEPTH_EXP2)-1];

    // Power-on contents are weakly not taken
    initial begin
        for (int i = 0; i < (1 << DEPTH_EXP2); i++) begin
            mem[i] = DATA_WIDTH'(`BPU_CTR_INIT);
        end
    end

    always_ff @(posedge clk) begin
        douta <= mem[addra];
    end

    always_ff @(posedge clk) begin
        doutb <= mem[addrb];
        if (web) begin
            mem[addrb] <= dinb;
        end
    end

endmodule

// ==== design/bpu_base_predictor.sv ====
/* Bimodal direction lookup, one prediction per fetch PC.
   The table read is registered, so pred arrives one cycle after the query. */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bpu_base_predictor (
    input  logic                  clk,
    input  logic                  arst_n,
    input  bpu_pkg::fetch_query_t fetch,
    output bpu_pkg::pht_idx_t     query_idx,
    input  bpu_pkg::ctr_t         query_ctr,
    output bpu_pkg::pred_t        pred
);

    logic valid_q;

    // Word-aligned PC bits select the counter
    assign query_idx = fetch.pc[`BPU_PC_IDX_LSB +: `BPU_TABLE_DEPTH_EXP2];

    // Matches the RAM read latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch.valid;
        end
    end

    assign pred.valid = valid_q;

    // Upper half of the counter range means taken
    assign pred.taken = query_ctr[`BPU_CTR_WIDTH-1];

endmodule

// ==== design/bpu_commit_updater.sv ====
/* Trains the PHT at commit and keeps the update and misprediction counts.
   The write request goes out in the same cycle as the commit record. */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bpu_commit_updater (
    input  logic                            clk,
    input  logic                            arst_n,
    input  bpu_pkg::commit_update_t         commit,
    input  logic                            stat_clear,
    output bpu_pkg::pht_req_t               req,
    output logic [`BPU_AXIL_DATA_WIDTH-1:0] update_count,
    output logic [`BPU_AXIL_DATA_WIDTH-1:0] mispredict_count
);

    bpu_pkg::ctr_dir_e old_dir;
    bpu_pkg::ctr_t     new_ctr;
    logic              mispredict;

    assign old_dir = bpu_pkg::ctr_dir_e'(commit.ctr_bits);

    // Saturating step toward the actual outcome
    always_comb begin
        case (old_dir)
            bpu_pkg::STRONG_NT: new_ctr = commit.taken ? bpu_pkg::WEAK_NT : bpu_pkg::STRONG_NT;
            bpu_pkg::STRONG_T:  new_ctr = commit.taken ? bpu_pkg::STRONG_T : bpu_pkg::WEAK_T;
            default:            new_ctr = commit.taken ? commit.ctr_bits + 1'b1
                                                       : commit.ctr_bits - 1'b1;
        endcase
    end

    assign mispredict = commit.ctr_bits[`BPU_CTR_WIDTH-1] != commit.taken;

    assign req.valid = commit.valid;
    assign req.write = commit.valid;
    assign req.idx   = commit.pc[`BPU_PC_IDX_LSB +: `BPU_TABLE_DEPTH_EXP2];
    assign req.wdata = new_ctr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            update_count     <= '0;
            mispredict_count <= '0;
        end else if (stat_clear) begin
            update_count     <= '0;
            mispredict_count <= '0;
        end else if (commit.valid) begin
            update_count <= update_count + 1'b1;
            if (mispredict) begin
                mispredict_count <= mispredict_count + 1'b1;
            end
        end
    end

endmodule

// ==== design/bpu_pht_arbiter.sv ====
/* Fixed-priority mux onto PHT port B.
   Commit updates always win and the host only gets cycles without a commit. */
`timescale 1ns/1ns

module bpu_pht_arbiter (
    input  bpu_pkg::pht_req_t updater_req,
    input  bpu_pkg::pht_req_t host_req,
    output logic              host_grant,
    output logic              web,
    output bpu_pkg::pht_idx_t addrb,
    output bpu_pkg::ctr_t     dinb
);

    bpu_pkg::pht_req_t sel_req;

    // Commit cannot be stalled so it never waits here
    assign host_grant = host_req.valid & ~updater_req.valid;

    always_comb begin
        if (updater_req.valid) begin
            sel_req = updater_req;
        end else begin
            sel_req = host_req;
        end
    end

    // Idle cycles still read at the host address
    assign web   = sel_req.valid & sel_req.write;
    assign addrb = sel_req.idx;
    assign dinb  = sel_req.wdata;

endmodule

// ==== design/bpu_axil_host.sv ====
/* AXI4-Lite slave for counter preload and inspection and the statistics.
   Handles one transaction at a time and sends table accesses through the PHT arbiter. */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bpu_axil_host (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [`BPU_AXIL_ADDR_WIDTH-1:0] s_awaddr,
    input  logic                            s_awvalid,
    output logic                            s_awready,
    input  logic [`BPU_AXIL_DATA_WIDTH-1:0] s_wdata,
    input  logic                            s_wvalid,
    output logic                            s_wready,
    output logic [1:0]                      s_bresp,
    output logic                            s_bvalid,
    input  logic                            s_bready,
    input  logic [`BPU_AXIL_ADDR_WIDTH-1:0] s_araddr,
    input  logic                            s_arvalid,
    output logic                            s_arready,
    output logic [`BPU_AXIL_DATA_WIDTH-1:0] s_rdata,
    output logic [1:0]                      s_rresp,
    output logic                            s_rvalid,
    input  logic                            s_rready,
    output bpu_pkg::pht_req_t               host_req,
    input  logic                            host_grant,
    input  bpu_pkg::ctr_t                   table_rdata,
    input  logic [`BPU_AXIL_DATA_WIDTH-1:0] update_count,
    input  logic [`BPU_AXIL_DATA_WIDTH-1:0] mispredict_count,
    output logic                            stat_clear
);

    bpu_pkg::host_state_e state;
    bpu_pkg::axil_resp_e  resp;
    logic                 aw_take;
    logic                 ar_take;
    logic                 data_due;

    // Writes need AW and W together and take precedence over reads
    assign aw_take    = (state == bpu_pkg::IDLE) && s_awvalid && s_wvalid;
    assign ar_take    = (state == bpu_pkg::IDLE) && s_arvalid && !aw_take;
    assign s_awready  = aw_take;
    assign s_wready   = aw_take;
    assign s_arready  = ar_take;
    assign stat_clear = aw_take && (s_awaddr == `BPU_STAT_UPDATES);
    assign s_bresp    = resp;
    assign s_rresp    = resp;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= bpu_pkg::IDLE;
            host_req <= '0;
            data_due <= 1'b0;
            resp     <= bpu_pkg::OKAY;
            s_bvalid <= 1'b0;
            s_rvalid <= 1'b0;
            s_rdata  <= '0;
        end else begin
            case (state)
                bpu_pkg::IDLE: begin
                    if (aw_take && s_awaddr < `BPU_STAT_BASE) begin
                        host_req <= '{valid: 1'b1, write: 1'b1,
                                      idx: s_awaddr[`BPU_PC_IDX_LSB +: `BPU_TABLE_DEPTH_EXP2],
                                      wdata: s_wdata[`BPU_CTR_WIDTH-1:0]};
                        state    <= bpu_pkg::TABLE_WAIT;
                    end else if (aw_take) begin
                        // Only the update count address clears and the rest is read-only
                        resp     <= (s_awaddr == `BPU_STAT_UPDATES) ? bpu_pkg::OKAY
                                                                    : bpu_pkg::SLVERR;
                        s_bvalid <= 1'b1;
                        state    <= bpu_pkg::RESP;
                    end else if (ar_take && s_araddr < `BPU_STAT_BASE) begin
                        host_req <= '{valid: 1'b1, write: 1'b0,
                                      idx: s_araddr[`BPU_PC_IDX_LSB +: `BPU_TABLE_DEPTH_EXP2],
                                      wdata: '0};
                        state    <= bpu_pkg::TABLE_WAIT;
                    end else if (ar_take) begin
                        if (s_araddr == `BPU_STAT_UPDATES) begin
                            s_rdata <= update_count;
                            resp    <= bpu_pkg::OKAY;
                        end else if (s_araddr == `BPU_STAT_MISPREDICTS) begin
                            s_rdata <= mispredict_count;
                            resp    <= bpu_pkg::OKAY;
                        end else begin
                            s_rdata <= '0;
                            resp    <= bpu_pkg::SLVERR;
                        end
                        s_rvalid <= 1'b1;
                        state    <= bpu_pkg::RESP;
                    end
                end
                bpu_pkg::TABLE_WAIT: begin
                    if (data_due) begin
                        // RAM output register holds the word read at grant
                        data_due <= 1'b0;
                        s_rdata  <= `BPU_AXIL_DATA_WIDTH'(table_rdata);
                        resp     <= bpu_pkg::OKAY;
                        s_rvalid <= 1'b1;
                        state    <= bpu_pkg::RESP;
                    end else if (host_grant) begin
                        host_req.valid <= 1'b0;
                        if (host_req.write) begin
                            resp     <= bpu_pkg::OKAY;
                            s_bvalid <= 1'b1;
                            state    <= bpu_pkg::RESP;
                        end else begin
                            data_due <= 1'b1;
                        end
                    end
                end
                bpu_pkg::RESP: begin
                    if ((s_bvalid && s_bready) || (s_rvalid && s_rready)) begin
                        s_bvalid <= 1'b0;
                        s_rvalid <= 1'b0;
                        state    <= bpu_pkg::IDLE;
                    end
                end
                default: state <= bpu_pkg::IDLE;
            endcase
        end
    end

endmodule

// ==== design/bpu_top.sv ====
/* Base direction predictor subsystem with PHT, commit trainer and AXI4-Lite host port.
   Fetch and commit streams have no back-pressure. */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bpu_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  bpu_pkg::fetch_query_t           fetch,
    output bpu_pkg::pred_t                  pred,
    input  bpu_pkg::commit_update_t         commit,
    input  logic [`BPU_AXIL_ADDR_WIDTH-1:0] s_awaddr,
    input  logic                            s_awvalid,
    output logic                            s_awready,
    input  logic [`BPU_AXIL_DATA_WIDTH-1:0] s_wdata,
    input  logic                            s_wvalid,
    output logic                            s_wready,
    output logic [1:0]                      s_bresp,
    output logic                            s_bvalid,
    input  logic                            s_bready,
    input  logic [`BPU_AXIL_ADDR_WIDTH-1:0] s_araddr,
    input  logic                            s_arvalid,
    output logic                            s_arready,
    output logic [`BPU_AXIL_DATA_WIDTH-1:0] s_rdata,
    output logic [1:0]                      s_rresp,
    output logic                            s_rvalid,
    input  logic                            s_rready
);

    bpu_pkg::pht_idx_t               query_idx;
    bpu_pkg::ctr_t                   query_ctr;
    bpu_pkg::pht_req_t               updater_req;
    bpu_pkg::pht_req_t               host_req;
    logic                            host_grant;
    logic                            web;
    bpu_pkg::pht_idx_t               addrb;
    bpu_pkg::ctr_t                   dinb;
    bpu_pkg::ctr_t                   table_rdata;
    logic [`BPU_AXIL_DATA_WIDTH-1:0] update_count;
    logic [`BPU_AXIL_DATA_WIDTH-1:0] mispredict_count;
    logic                            stat_clear;

    bpu_pht_ram #(
        .DATA_WIDTH(`BPU_CTR_WIDTH),
        .DEPTH_EXP2(`BPU_TABLE_DEPTH_EXP2)
    ) u_pht_ram (
        .clk  (clk),
        .addra(query_idx),
        .douta(query_ctr),
        .web  (web),
        .addrb(addrb),
        .dinb (dinb),
        .doutb(table_rdata)
    );

    bpu_base_predictor u_base_predictor (.*);

    bpu_commit_updater u_commit_updater (.*, .req(updater_req));

    bpu_pht_arbiter u_pht_arbiter (.*);

    bpu_axil_host u_axil_host (.*);

endmodule

// ==== verif/bpu_tb.sv ====
/* Self-checking testbench for the branch predictor subsystem.
   Replays the operations in verif/bpu_testdata.txt and checks each result. */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bpu_tb;

    localparam int    RESET_CYCLES    = 10;
    localparam int    CYCLES_PER_LINE = 40;
    localparam string DATA_FILE       = "verif/bpu_testdata.txt";

    logic                    clk;
    logic                    arst_n;
    bpu_pkg::fetch_query_t   fetch;
    bpu_pkg::pred_t          pred;
    bpu_pkg::commit_update_t commit;
    logic [12:0]             s_awaddr;
    logic                    s_awvalid;
    logic                    s_awready;
    logic [31:0]             s_wdata;
    logic                    s_wvalid;
    logic                    s_wready;
    logic [1:0]              s_bresp;
    logic                    s_bvalid;
    logic                    s_bready;
    logic [12:0]             s_araddr;
    logic                    s_arvalid;
    logic                    s_arready;
    logic [31:0]             s_rdata;
    logic [1:0]              s_rresp;
    logic                    s_rvalid;
    logic                    s_rready;

    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;
    int unsigned b_seen_cycle;
    int unsigned burst_end;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          n_lines = 0;
    int          fd;
    string       line;
    string       waiting_on = "reset";
    logic [31:0] lfsr = 32'hc52175ca;

    bpu_top u_bpu_top (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("TIMEOUT: %s never completed within %0d cycles", waiting_on, cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic bit is_data_line(input string s);
        return s.len() > 1 && s[0] != "#";
    endfunction

    task automatic check_pred(input bpu_pkg::pred_t act, input bpu_pkg::pred_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR pred: expected %h, got %h", exp, act);
        end
    endtask

    task automatic check_ctr(input bpu_pkg::ctr_t act, input bpu_pkg::ctr_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR s_rdata[1:0]: expected %h, got %h", exp, act);
        end
    endtask

    task automatic check_resp(input string name, input bpu_pkg::axil_resp_e act,
                              input bpu_pkg::axil_resp_e exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] act, input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic send_query(input logic [31:0] pc, input logic taken);
        fetch = '{valid: 1'b1, pc: pc};
        @(negedge clk);
        check_pred(pred, '{valid: 1'b1, taken: taken});
        fetch.valid = 1'b0;
    endtask

    task automatic send_commit(input logic [31:0] pc, input logic taken, input bpu_pkg::ctr_t ctr);
        commit = '{valid: 1'b1, taken: taken, pc: pc, ctr_bits: ctr};
        @(negedge clk);
        commit.valid = 1'b0;
    endtask

    task automatic write_reg(input logic [12:0] addr, input logic [31:0] data,
                             output bpu_pkg::axil_resp_e resp);
        logic [31:0] delay;
        logic [1:0]  first;
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        waiting_on = "write address and data handshake";
        #1;
        while (!s_awready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        s_awvalid  = 1'b0;
        s_wvalid   = 1'b0;
        waiting_on = "write response";
        while (!s_bvalid) @(negedge clk);
        b_seen_cycle = cycle_count;
        first = s_bresp;
        // B ready stays low for a random stretch
        delay = take_bits(3);
        repeat (delay) @(negedge clk);
        if (!s_bvalid || s_bresp !== first) begin
            errors++;
            $display("Write response was not held while s_bready was low");
        end
        resp = bpu_pkg::axil_resp_e'(s_bresp);
        s_bready = 1'b1;
        @(negedge clk);
        s_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [12:0] addr, output logic [31:0] data,
                            output bpu_pkg::axil_resp_e resp);
        logic [31:0] delay;
        logic [31:0] first_data;
        logic [1:0]  first_resp;
        s_araddr   = addr;
        s_arvalid  = 1'b1;
        waiting_on = "read address handshake";
        #1;
        while (!s_arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        s_arvalid  = 1'b0;
        waiting_on = "read data";
        while (!s_rvalid) @(negedge clk);
        first_data = s_rdata;
        first_resp = s_rresp;
        delay = take_bits(3);
        repeat (delay) @(negedge clk);
        if (!s_rvalid || s_rdata !== first_data || s_rresp !== first_resp) begin
            errors++;
            $display("Read data was not held while s_rready was low");
        end
        data = s_rdata;
        resp = bpu_pkg::axil_resp_e'(s_rresp);
        s_rready = 1'b1;
        @(negedge clk);
        s_rready = 1'b0;
    endtask

    task automatic read_stats(input logic [31:0] exp_updates, input logic [31:0] exp_mispredicts);
        logic [31:0]         data;
        bpu_pkg::axil_resp_e resp;
        read_reg(`BPU_STAT_UPDATES, data, resp);
        check_resp("s_rresp", resp, bpu_pkg::OKAY);
        check_count("update_count", data, exp_updates);
        read_reg(`BPU_STAT_MISPREDICTS, data, resp);
        check_resp("s_rresp", resp, bpu_pkg::OKAY);
        check_count("mispredict_count", data, exp_mispredicts);
    endtask

    task automatic run_line(input string s);
        byte                 op;
        logic [31:0]         a0 = '0;
        logic [31:0]         a1 = '0;
        logic [31:0]         a2 = '0;
        logic [31:0]         a3 = '0;
        logic [31:0]         a4 = '0;
        logic [31:0]         a5 = '0;
        logic [31:0]         a6 = '0;
        logic [31:0]         rdata;
        bpu_pkg::axil_resp_e resp;
        int                  errors_before;
        op = s[0];
        void'($sscanf(s.substr(1, s.len() - 1), "%h %h %h %h %h %h %h",
                      a0, a1, a2, a3, a4, a5, a6));
        errors_before = errors;
        tests++;
        waiting_on = $sformatf("test %0d", tests);
        case (op)
            "Q": send_query(a0, a1[0]);
            "U": send_commit(a0, a1[0], a2[1:0]);
            "S": read_stats(a0, a1);
            "W": begin
                write_reg(a0[12:0], a1, resp);
                check_resp("s_bresp", resp, bpu_pkg::axil_resp_e'(a2[1:0]));
            end
            "R": begin
                read_reg(a0[12:0], rdata, resp);
                check_resp("s_rresp", resp, bpu_pkg::axil_resp_e'(a2[1:0]));
                if (a0[12:0] < `BPU_STAT_BASE) begin
                    check_ctr(rdata[1:0], a1[1:0]);
                    check_count("s_rdata[31:2]", {2'b00, rdata[31:2]}, {2'b00, a1[31:2]});
                end else begin
                    check_count("s_rdata", rdata, a1);
                end
            end
            "C": begin
                // Host write racing a burst of back-to-back commits
                fork
                    begin
                        commit = '{valid: 1'b1, taken: a5[0], pc: a4, ctr_bits: a6[1:0]};
                        repeat (a3) @(negedge clk);
                        commit.valid = 1'b0;
                        burst_end = cycle_count;
                    end
                    write_reg(a0[12:0], a1, resp);
                join
                check_resp("s_bresp", resp, bpu_pkg::axil_resp_e'(a2[1:0]));
                checks++;
                if (b_seen_cycle <= burst_end) begin
                    errors++;
                    $display("Host write answered at cycle %0d, before commits ended at %0d",
                             b_seen_cycle, burst_end);
                end
            end
            default: begin
                errors++;
                $display("Unknown operation '%c' in the data file", op);
            end
        endcase
        $display("test %0d %c %s", tests, op, (errors == errors_before) ? "ok" : "fail");
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        fetch     = '0;
        commit    = '0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open %s", DATA_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (is_data_line(line)) n_lines++;
            end
            $fclose(fd);
            cycle_limit = CYCLES_PER_LINE * n_lines + RESET_CYCLES;
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            arst_n = 1'b1;
            fd = $fopen(DATA_FILE, "r");
            while ($fgets(line, fd) != 0) begin
                if (is_data_line(line)) run_line(line);
            end
            $fclose(fd);
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && tests > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/bpu_testdata.txt ====
# Q pc taken | U pc taken ctr | W addr data resp | R addr data resp | S updates mispredicts
# C addr data resp commits pc taken ctr (host write during back-to-back commits), all hex
Q 00000040 0
Q 00000044 0
Q 00000048 0
W 0010 00000003 0
R 0010 00000003 0
Q 00000010 1
W 0014 00000002 0
Q 00000014 1
U 00000100 1 1
U 00000100 1 2
U 00000100 1 3
R 0100 00000003 0
Q 00000100 1
U 00000100 0 3
U 00000100 0 2
U 00000100 0 1
U 00000100 0 0
Q 00000100 0
R 0100 00000000 0
S 00000007 00000003
W 1004 00000005 2
R 1008 00000000 2
S 00000007 00000003
W 1000 00000000 0
S 00000000 00000000
C 0200 00000003 0 5 00000300 1 1
R 0200 00000003 0
R 0300 00000002 0
S 00000005 00000005

// ==== build.f ====
+incdir+design
design/bpu_pkg.sv
design/bpu_pht_ram.sv
design/bpu_base_predictor.sv
design/bpu_commit_updater.sv
design/bpu_pht_arbiter.sv
design/bpu_axil_host.sv
design/bpu_top.sv
verif/bpu_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   list these targets"

test:
	verilator --binary -f build.f --top-module bpu_tb -o bpu_sim
	./obj_dir/bpu_sim > sim.log 2>&1
	@cat sim.log
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
